// File: vlog.f
logic/rv32i_lsu_pkg.sv
logic/wb_bus_pkg.sv
logic/agu_stage.sv
logic/exe_mem_reg.sv
logic/mem_stage.sv
logic/data_ram.sv
logic/lsu_top.sv
sim/lsu_tb.sv

// File: run.sh
#!/usr/bin/env bash
# build the load/store testbench with verilator and run it
# exit status is 0 only when the pass line shows up in the output

cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -Wno-fatal --top-module lsu_tb -f vlog.f -o lsu_sim \
    && ./obj_dir/lsu_sim | tee /dev/stderr | grep -qx "=== PASS ===" \
    && echo "simulation passed" \
    || { echo "simulation failed"; exit 1; }

// File: sim/lsu_tb.sv
/* testbench for the load/store path; directed and random loads and stores checked
   against a shadow memory and an in-order queue of expected writeback records */
`timescale 1ns/1ns

module lsu_tb;

    localparam int n_directed = 68;   // issues in the directed part
    localparam int n_random   = 200;

    logic                   clk = 1'b0;
    logic                   rst;
    logic                   op_valid;
    rv32i_lsu_pkg::issue_t  op_in;
    logic                   op_ready;
    logic                   wb_valid;
    rv32i_lsu_pkg::wb_rec_t wb_rec;

    logic [31:0]            shadow [rv32i_lsu_pkg::ram_words];  // model of the data ram
    rv32i_lsu_pkg::wb_rec_t expq [$];  // expected records in issue order
    int                     dueq [$];  // cycle each record is due
    int                     cyc_cnt;
    int                     acc_count;  // accepted issues
    int                     wb_count;   // wb_valid pulses seen
    int                     errors;
    int                     seed = 32'h2392_8dd3;
    logic                   legal_prev;  // legal issue accepted at the last edge
    logic                   iss_fault;

    lsu_top dut0 (.clk(clk), .rst(rst), .op_valid(op_valid), .op_in(op_in),
                  .op_ready(op_ready), .wb_valid(wb_valid), .wb_rec(wb_rec));

    always #4 clk = ~clk;

    task automatic report_mismatch(input string name, input logic [31:0] got,
                                   input logic [31:0] exp);
        $display("Mismatch %s: got %h expected %h at %0t", name, got, exp, $time);
        errors++;
    endtask

    // pick the addressed lanes of a memory word and extend them
    function automatic logic [31:0] load_value(input rv32i_lsu_pkg::mem_op_e op,
                                               input logic [31:0] word, input int off);
        logic [7:0]  lanes [4];
        logic [31:0] res;
        for (int i = 0; i < 4; i++)
            lanes[i] = word[8*i +: 8];
        case (op)
            rv32i_lsu_pkg::op_lb:  res = {{24{lanes[off][7]}}, lanes[off]};
            rv32i_lsu_pkg::op_lbu: res = {24'h0, lanes[off]};
            rv32i_lsu_pkg::op_lh:  res = {{16{lanes[off+1][7]}}, lanes[off+1], lanes[off]};
            rv32i_lsu_pkg::op_lhu: res = {16'h0, lanes[off+1], lanes[off]};
            default:               res = word;
        endcase
        return res;
    endfunction

    // expected record of an accepted issue; stores update the shadow at once
    task automatic predict_issue(input rv32i_lsu_pkg::issue_t iss, output logic fault);
        logic [31:0]            addr;
        logic [31:0]            word;
        logic [7:0]             idx;
        int                     nbytes;
        int                     off;
        rv32i_lsu_pkg::wb_rec_t rec;
        addr = iss.rs1 + iss.imm;
        idx  = addr[rv32i_lsu_pkg::ram_addr_bits+1:2];  // ram aliases above this
        off  = int'(addr[1:0]);
        word = shadow[idx];
        case (iss.op)
            rv32i_lsu_pkg::op_lb, rv32i_lsu_pkg::op_lbu, rv32i_lsu_pkg::op_sb: nbytes = 1;
            rv32i_lsu_pkg::op_lh, rv32i_lsu_pkg::op_lhu, rv32i_lsu_pkg::op_sh: nbytes = 2;
            default: nbytes = 4;
        endcase
        rec         = '0;
        rec.rd      = iss.rd;
        rec.order   = acc_count[7:0];
        rec.addr    = addr[rv32i_lsu_pkg::rec_addr_bits-1:0];
        rec.is_load = iss.op inside {rv32i_lsu_pkg::op_lb, rv32i_lsu_pkg::op_lh,
                                     rv32i_lsu_pkg::op_lw, rv32i_lsu_pkg::op_lbu,
                                     rv32i_lsu_pkg::op_lhu};
        rec.fault   = (off % nbytes) != 0;
        if (!rec.fault && rec.is_load)
            rec.data = load_value(iss.op, word, off);
        if (!rec.fault && !rec.is_load) begin
            for (int b = 0; b < nbytes; b++)
                word[8*(off+b) +: 8] = iss.rs2[8*b +: 8];  // low bytes of rs2 only
            shadow[idx] = word;
        end
        expq.push_back(rec);
        dueq.push_back(cyc_cnt + (rec.fault ? 1 : 2));  // fault skips the bus
        fault = rec.fault;
    endtask

    task automatic check_writeback();
        rv32i_lsu_pkg::wb_rec_t exp;
        int                     due;
        wb_count++;
        assert (expq.size() > 0) else begin
            errors++;
            $display("writeback at %0t with no issued instruction outstanding", $time);
        end
        if (expq.size() > 0) begin
            exp = expq.pop_front();
            due = dueq.pop_front();
            assert (wb_rec.order == exp.order)
                else report_mismatch("wb_rec.order", wb_rec.order, exp.order);
            assert (wb_rec.data == exp.data)
                else report_mismatch("wb_rec.data", wb_rec.data, exp.data);
            assert (wb_rec.fault == exp.fault)
                else report_mismatch("wb_rec.fault", wb_rec.fault, exp.fault);
            assert (wb_rec.is_load == exp.is_load)
                else report_mismatch("wb_rec.is_load", wb_rec.is_load, exp.is_load);
            assert (wb_rec.rd == exp.rd) else report_mismatch("wb_rec.rd", wb_rec.rd, exp.rd);
            assert (wb_rec.addr[9:0] == exp.addr[9:0])
                else report_mismatch("wb_rec.addr", wb_rec.addr[9:0], exp.addr[9:0]);
            assert (cyc_cnt == due) else begin
                errors++;
                $display("writeback of order %0h came at cycle %0d, due at cycle %0d",
                         exp.order, cyc_cnt, due);
            end
        end
    endtask

    // the monitor reads everything as it stood just before the edge
    always @(posedge clk) begin
        if (!rst) begin
            cyc_cnt++;
            if (legal_prev)
                assert (!op_ready) else report_mismatch("op_ready", op_ready, 0);
            legal_prev = 1'b0;
            if (wb_valid)
                check_writeback();  // retire first since a new issue may land this edge
            if (op_valid && op_ready) begin
                predict_issue(op_in, iss_fault);
                legal_prev = !iss_fault;
                acc_count++;
            end
        end
    end

    // drives one issue and returns 1 ns after the edge that took it
    task automatic issue_op(input rv32i_lsu_pkg::mem_op_e op, input logic [31:0] base,
                            input logic [31:0] offs, input logic [31:0] data,
                            input logic [4:0] rd);
        op_valid  = 1'b1;
        op_in.op  = op;
        op_in.rs1 = base;
        op_in.imm = offs;
        op_in.rs2 = data;
        op_in.rd  = rd;
        @(posedge clk);
        while (!op_ready)
            @(posedge clk);
        #1;
        op_valid = 1'b0;
    endtask

    initial begin
        rv32i_lsu_pkg::mem_op_e rop;
        logic [31:0]            base;
        logic [31:0]            offs;
        rst        = 1'b1;
        op_valid   = 1'b0;
        op_in      = '0;
        cyc_cnt    = 0;
        acc_count  = 0;
        wb_count   = 0;
        errors     = 0;
        legal_prev = 1'b0;
        for (int i = 0; i < rv32i_lsu_pkg::ram_words; i++)
            shadow[i] = '0;
        repeat (4) @(posedge clk);
        #1 rst = 1'b0;
        assert (op_ready && !wb_valid && !dut0.exe_mem_valid && dut0.buf0.order_cnt == 0)
            else begin
            errors++;
            $display("handshake or buffer not idle after reset");
        end
        assert (!dut0.bus_m2s.cyc && !dut0.bus_m2s.stb && !dut0.bus_m2s.we
                && !dut0.bus_s2m.ack) else begin
            errors++;
            $display("bus not idle after reset");
        end

        // word store and load back with a negative offset on the load
        issue_op(rv32i_lsu_pkg::op_sw, 32'h10, 0, 32'h1234_5678, 5'd1);
        issue_op(rv32i_lsu_pkg::op_lw, 32'h14, -4, 0, 5'd2);
        // partial stores touch only their lanes
        issue_op(rv32i_lsu_pkg::op_sw, 32'h20, 0, 32'haabb_ccdd, 5'd3);
        issue_op(rv32i_lsu_pkg::op_sb, 32'h20, 1, 32'hdead_be11, 5'd3);
        issue_op(rv32i_lsu_pkg::op_sh, 32'h20, 2, 32'hcafe_5566, 5'd3);
        issue_op(rv32i_lsu_pkg::op_lw, 32'h20, 0, 0, 5'd4);
        // sign and zero extension on every lane
        issue_op(rv32i_lsu_pkg::op_sw, 32'h30, 0, 32'h80ff_7f01, 5'd5);
        for (int i = 0; i < 4; i++) begin
            issue_op(rv32i_lsu_pkg::op_lb, 32'h30, i, 0, 5'd6);
            issue_op(rv32i_lsu_pkg::op_lbu, 32'h30, i, 0, 5'd7);
        end
        for (int i = 0; i < 4; i += 2) begin
            issue_op(rv32i_lsu_pkg::op_lh, 32'h30, i, 0, 5'd8);
            issue_op(rv32i_lsu_pkg::op_lhu, 32'h30, i, 0, 5'd9);
        end
        // misaligned ops fault and leave the word alone
        issue_op(rv32i_lsu_pkg::op_sw, 32'h40, 0, 32'h0bad_f00d, 5'd10);
        issue_op(rv32i_lsu_pkg::op_sh, 32'h40, 1, 32'hffff_ffff, 5'd11);
        issue_op(rv32i_lsu_pkg::op_sw, 32'h40, 2, 32'hffff_ffff, 5'd11);
        issue_op(rv32i_lsu_pkg::op_sw, 32'h40, 3, 32'hffff_ffff, 5'd11);
        issue_op(rv32i_lsu_pkg::op_lh, 32'h40, 3, 0, 5'd12);
        issue_op(rv32i_lsu_pkg::op_lhu, 32'h40, 1, 0, 5'd12);
        issue_op(rv32i_lsu_pkg::op_lw, 32'h40, 1, 0, 5'd12);
        issue_op(rv32i_lsu_pkg::op_lw, 32'h40, 0, 0, 5'd13);
        // burst of faults issued one per cycle
        for (int i = 0; i < 40; i++)
            issue_op(i[0] ? rv32i_lsu_pkg::op_sw : rv32i_lsu_pkg::op_lh, 32'h80,
                     i[0] ? 32'd2 : 32'd1, i, 5'd14);
        issue_op(rv32i_lsu_pkg::op_lw, 32'h80, 0, 0, 5'd15);

        for (int n = 0; n < n_random; n++) begin
            rop  = rv32i_lsu_pkg::mem_op_e'(3'($random(seed)));
            base = 32'd64 + {$random(seed)} % 896;  // keeps base+offs inside the ram
            offs = $random(seed) % 64;
            issue_op(rop, base, offs, $random(seed), 5'(n));
            if (($random(seed) & 3) == 0) begin  // occasional idle cycle
                @(posedge clk);
                #1;
            end
        end

        while (wb_count != acc_count)
            @(posedge clk);
        repeat (4) @(posedge clk);
        assert (wb_count == acc_count && expq.size() == 0) else begin
            errors++;
            $display("issue lost or duplicated, %0d issues but %0d writebacks",
                     acc_count, wb_count);
        end
        $display("issues %0d, writebacks %0d, errors %0d", acc_count, wb_count, errors);
        if (errors == 0)
            $display("=== PASS ===");
        else
            $display("=== FAIL ===");
        $finish;
    end

    // watchdog
    initial begin
        repeat ((n_directed + n_random) * 20 + 100) @(posedge clk);
        $display("timeout, run did not finish in %0d cycles",
                 (n_directed + n_random) * 20 + 100);
        $display("=== FAIL ===");
        $finish;
    end

endmodule

// File: logic/lsu_top.sv
/* load/store path top level: address generation, exe/mem buffer,
   memory stage and data ram joined in a line */
`timescale 1ns/1ns

module lsu_top (
    input  logic                   clk,
    input  logic                   rst,
    input  logic                   op_valid,
    input  rv32i_lsu_pkg::issue_t  op_in,
    output logic                   op_ready,
    output logic                   wb_valid,
    output rv32i_lsu_pkg::wb_rec_t wb_rec
);

    logic                      agu_valid;
    logic                      agu_ready;
    rv32i_lsu_pkg::ctrl_word_t agu_ctrl;    // order still zero here
    logic                      exe_mem_valid;
    rv32i_lsu_pkg::ctrl_word_t ctrl_w_mem;
    logic                      mem_rdy;
    wb_bus_pkg::wb_m2s_t       bus_m2s;
    wb_bus_pkg::wb_s2m_t       bus_s2m;

    agu_stage agu0 (
        .clk(clk), .rst(rst),
        .op_valid(op_valid), .op_in(op_in), .op_ready(op_ready),
        .down_ready(agu_ready), .down_valid(agu_valid), .ctrl(agu_ctrl)
    );

    exe_mem_reg buf0 (
        .clk(clk), .rst(rst),
        .in_valid(agu_valid), .in_ctrl(agu_ctrl), .in_ready(agu_ready),
        .exe_mem_valid(exe_mem_valid), .ctrl_w_mem(ctrl_w_mem), .mem_rdy(mem_rdy)
    );

    mem_stage mem0 (
        .clk(clk), .rst(rst),
        .exe_mem_valid(exe_mem_valid), .ctrl_w_mem(ctrl_w_mem), .mem_rdy(mem_rdy),
        .wb_out(bus_m2s), .wb_in(bus_s2m), .wb_valid(wb_valid), .wb_rec(wb_rec)
    );

    data_ram ram0 (.clk(clk), .rst(rst), .wb_in(bus_m2s), .wb_out(bus_s2m));

endmodule

// File: logic/data_ram.sv
/* word-wide wishbone classic slave ram with byte selects; one wait state,
   ack comes in the second cycle of every strobe */
`timescale 1ns/1ns

module data_ram (
    input  logic                clk,
    input  logic                rst,
    input  wb_bus_pkg::wb_m2s_t wb_in,
    output wb_bus_pkg::wb_s2m_t wb_out
);

    logic [wb_bus_pkg::wb_dat_bits-1:0] mem [rv32i_lsu_pkg::ram_words];
    logic [rv32i_lsu_pkg::ram_addr_bits-1:0] idx;
    logic [wb_bus_pkg::wb_dat_bits-1:0] rdat_q;   // word read in the sample cycle
    logic                               ack_q;
    logic                               req;

    assign idx = wb_in.adr[rv32i_lsu_pkg::ram_addr_bits-1:0];  // upper bits alias
    assign req = wb_in.cyc && wb_in.stb;

    initial begin
        for (int i = 0; i < rv32i_lsu_pkg::ram_words; i++)
            mem[i] = '0;
    end

    // first strobe cycle samples, second one acks; ack drops right after
    always_ff @(posedge clk) begin
        if (rst)
            ack_q <= 1'b0;
        else
            ack_q <= req && !ack_q;
    end

    always_ff @(posedge clk) begin
        if (req && !ack_q)
            rdat_q <= mem[idx];
        if (req && ack_q && wb_in.we) begin   // commit at the end of the ack cycle
            for (int b = 0; b < wb_bus_pkg::wb_sel_bits; b++)
                if (wb_in.sel[b])
                    mem[idx][8*b +: 8] <= wb_in.dat[8*b +: 8];
        end
    end

    assign wb_out.ack = ack_q;
    assign wb_out.dat = ack_q ? rdat_q : '0;

    // a master that drops stb early would leave a stray ack
    a_ack_with_stb: assert property (@(posedge clk) disable iff (rst)
        wb_out.ack |-> wb_in.stb);

endmodule

// File: logic/mem_stage.sv
/* memory stage; runs the data access as a wishbone classic master, extends
   load data and emits one writeback record per instruction */
`timescale 1ns/1ns

module mem_stage (
    input  logic                      clk,
    input  logic                      rst,
    input  logic                      exe_mem_valid,
    input  rv32i_lsu_pkg::ctrl_word_t ctrl_w_mem,
    output logic                      mem_rdy,
    output wb_bus_pkg::wb_m2s_t       wb_out,
    input  wb_bus_pkg::wb_s2m_t       wb_in,
    output logic                      wb_valid,
    output rv32i_lsu_pkg::wb_rec_t    wb_rec
);

    typedef enum logic [1:0] {
        st_idle,   // nothing in flight
        st_bus,    // strobe raised, waiting for ack
        st_done    // previous word acked, don't strobe it again
    } mem_state_e;

    mem_state_e                           state, state_nxt;
    logic [rv32i_lsu_pkg::order_bits-1:0] done_order;  // order of last retired word
    logic                                 start;       // fresh word seen this cycle
    logic                                 needs_bus;
    logic [rv32i_lsu_pkg::xlen-1:0]       rd_shift;
    logic [rv32i_lsu_pkg::xlen-1:0]       ld_ext;

    assign needs_bus = (ctrl_w_mem.mem_read || ctrl_w_mem.mem_write) && !ctrl_w_mem.misaligned;
    // a word that was already acked must not look new
    assign start = exe_mem_valid && (state != st_bus)
                && !(state == st_done && ctrl_w_mem.order == done_order);

    always_comb begin
        wb_out     = '0;
        wb_out.cyc = (state == st_bus) || (start && needs_bus);
        wb_out.stb = wb_out.cyc;
        if (wb_out.cyc) begin  // request fields only while in a cycle
            wb_out.we  = ctrl_w_mem.mem_write;
            wb_out.adr = ctrl_w_mem.addr[31:2];
            wb_out.sel = ctrl_w_mem.sel;
            wb_out.dat = ctrl_w_mem.wdata;
        end
    end

    // retire on ack, or at once for a faulting word
    assign mem_rdy  = (wb_out.cyc && wb_in.ack) || (start && !needs_bus);
    assign wb_valid = mem_rdy;

    always_comb begin
        state_nxt = st_idle;
        if (mem_rdy)
            state_nxt = st_done;
        else if (wb_out.cyc)
            state_nxt = st_bus;                // hold until ack
        else if (state == st_done && exe_mem_valid)
            state_nxt = st_done;               // old word still sitting there
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            state      <= st_idle;
            done_order <= '0;
        end else begin
            state <= state_nxt;
            if (mem_rdy)
                done_order <= ctrl_w_mem.order;
        end
    end

    // pick the addressed lane and extend
    assign rd_shift = wb_in.dat >> {ctrl_w_mem.addr[1:0], 3'b000};
    always_comb begin
        unique case (ctrl_w_mem.op)
            rv32i_lsu_pkg::op_lb:  ld_ext = {{24{rd_shift[7]}}, rd_shift[7:0]};
            rv32i_lsu_pkg::op_lbu: ld_ext = {24'b0, rd_shift[7:0]};
            rv32i_lsu_pkg::op_lh:  ld_ext = {{16{rd_shift[15]}}, rd_shift[15:0]};
            rv32i_lsu_pkg::op_lhu: ld_ext = {16'b0, rd_shift[15:0]};
            rv32i_lsu_pkg::op_lw:  ld_ext = wb_in.dat;
            default:               ld_ext = '0;    // stores carry no data back
        endcase
    end

    always_comb begin
        wb_rec         = '0;
        wb_rec.rd      = ctrl_w_mem.rd;
        wb_rec.is_load = ctrl_w_mem.mem_read;
        wb_rec.fault   = ctrl_w_mem.misaligned;
        wb_rec.order   = ctrl_w_mem.order;
        wb_rec.addr    = ctrl_w_mem.addr[rv32i_lsu_pkg::rec_addr_bits-1:0];
        wb_rec.data    = ctrl_w_mem.misaligned ? '0 : ld_ext;
    end

    // the ram answers in the second cycle of every access
    a_ack_second: assert property (@(posedge clk) disable iff (rst)
        (wb_out.cyc && state != st_bus) |=> wb_in.ack);
    // classic handshake holds the request steady until the slave answers
    a_req_hold: assert property (@(posedge clk) disable iff (rst)
        (wb_out.cyc && !wb_in.ack) |=> (wb_out.cyc && $stable(wb_out.adr)));

endmodule

// File: logic/exe_mem_reg.sv
/* execute/memory pipeline register; holds one control word until the memory
   stage retires it and stamps each accepted word with its issue order */
`timescale 1ns/1ns

module exe_mem_reg (
    input  logic                      clk,
    input  logic                      rst,
    input  logic                      in_valid,
    input  rv32i_lsu_pkg::ctrl_word_t in_ctrl,
    output logic                      in_ready,
    output logic                      exe_mem_valid,
    output rv32i_lsu_pkg::ctrl_word_t ctrl_w_mem,
    input  logic                      mem_rdy
);

    logic [rv32i_lsu_pkg::order_bits-1:0] order_cnt;  // next order to hand out
    logic                                 valid_q;
    rv32i_lsu_pkg::ctrl_word_t            ctrl_q;

    // free when empty, or when the held word retires this cycle
    assign in_ready      = !valid_q || mem_rdy;
    assign exe_mem_valid = valid_q;
    assign ctrl_w_mem    = ctrl_q;

    always_ff @(posedge clk) begin
        if (rst) begin
            valid_q   <= 1'b0;
            order_cnt <= '0;
        end else if (in_ready) begin
            valid_q <= in_valid;              // load next or go empty
            if (in_valid)
                order_cnt <= order_cnt + 1'b1;  // wraps naturally
        end
    end

    // payload and its order stamp
    always_ff @(posedge clk) begin
        if (in_ready && in_valid) begin
            ctrl_q       <= in_ctrl;
            ctrl_q.order <= order_cnt;
        end
    end

    // memory stage may only retire something that is actually held
    a_rdy_needs_word: assert property (@(posedge clk) disable iff (rst)
        mem_rdy |-> exe_mem_valid);

endmodule

// File: logic/agu_stage.sv
/* address generation for loads and stores; combinational, turns an issued op
   into a control word with byte lanes, lane-aligned store data and a misalign flag */
`timescale 1ns/1ns

module agu_stage (
    input  logic                      clk,
    input  logic                      rst,
    input  logic                      op_valid,
    input  rv32i_lsu_pkg::issue_t     op_in,
    output logic                      op_ready,
    input  logic                      down_ready,
    output logic                      down_valid,
    output rv32i_lsu_pkg::ctrl_word_t ctrl
);

    logic [rv32i_lsu_pkg::xlen-1:0] eff_addr;
    logic [rv32i_lsu_pkg::xlen-1:0] st_raw;    // store value masked to its size
    logic [3:0]                     sel_raw;   // lanes before the address shift

    assign eff_addr   = op_in.rs1 + op_in.imm;
    assign down_valid = op_valid;
    assign op_ready   = down_ready;  // no storage here, ready comes from the buffer

    always_comb begin
        sel_raw = 4'b1111;
        st_raw  = op_in.rs2;
        ctrl    = '0;              // order stays zero, buffer stamps it
        ctrl.op = op_in.op;
        ctrl.rd = op_in.rd;
        ctrl.addr = eff_addr;
        unique case (op_in.op)
            rv32i_lsu_pkg::op_lb, rv32i_lsu_pkg::op_lbu, rv32i_lsu_pkg::op_sb: begin
                sel_raw = 4'b0001;
                st_raw  = {24'b0, op_in.rs2[7:0]};
            end
            rv32i_lsu_pkg::op_lh, rv32i_lsu_pkg::op_lhu, rv32i_lsu_pkg::op_sh: begin
                sel_raw = 4'b0011;
                st_raw  = {16'b0, op_in.rs2[15:0]};
                ctrl.misaligned = eff_addr[0];   // halfword must be 2-aligned
            end
            default: begin                        // lw, sw
                ctrl.misaligned = |eff_addr[1:0];
            end
        endcase
        ctrl.mem_write = op_in.op inside {rv32i_lsu_pkg::op_sb, rv32i_lsu_pkg::op_sh,
                                          rv32i_lsu_pkg::op_sw};
        ctrl.mem_read  = !ctrl.mem_write;
        // move lanes and data up to the byte offset
        ctrl.sel   = sel_raw << eff_addr[1:0];
        ctrl.wdata = st_raw << {eff_addr[1:0], 3'b000};
    end

    // producer must hold the op while it is stalled
    a_issue_hold: assert property (@(posedge clk) disable iff (rst)
        (op_valid && !op_ready) |=> (op_valid && $stable(op_in)));

endmodule

// File: logic/wb_bus_pkg.sv
/* bus-side types: wishbone classic request and response bundles
   shared by the memory stage master and the data ram slave */
package wb_bus_pkg;

    localparam int wb_adr_bits = 30; // word address, byte offset lives in sel
    localparam int wb_dat_bits = 32;
    localparam int wb_sel_bits = wb_dat_bits / 8;

    // master to slave
    typedef struct packed {
        logic                   cyc;
        logic                   stb;
        logic                   we;
        logic [wb_adr_bits-1:0] adr;
        logic [wb_sel_bits-1:0] sel;
        logic [wb_dat_bits-1:0] dat;  // write data
    } wb_m2s_t;

    // slave to master, no err or rty in this system
    typedef struct packed {
        logic                   ack;
        logic [wb_dat_bits-1:0] dat;  // read data, valid with ack
    } wb_s2m_t;

endpackage

// File: logic/rv32i_lsu_pkg.sv
/* cpu-side types for the load/store path: memory opcodes, issue and control words,
   and the writeback record handed to the register file */
package rv32i_lsu_pkg;

    localparam int xlen          = 32;  // data width
    localparam int ram_words     = 256; // data ram depth in words
    localparam int ram_addr_bits = 8;   // word index width into the ram
    localparam int rec_addr_bits = 23;  // low address bits kept in the wb record
    localparam int order_bits    = 8;   // issue order counter, wraps at 256

    // memory opcodes, loads first then stores
    typedef enum logic [2:0] {
        op_lb,
        op_lh,
        op_lw,
        op_lbu,
        op_lhu,
        op_sb,
        op_sh,
        op_sw
    } mem_op_e;

    // one memory instruction as it leaves execute
    typedef struct packed {
        mem_op_e         op;
        logic [xlen-1:0] rs1;   // base register value
        logic [xlen-1:0] imm;   // sign-extended offset
        logic [xlen-1:0] rs2;   // store source value
        logic [4:0]      rd;
    } issue_t;

    // control word held in the exe/mem register
    typedef struct packed {
        mem_op_e               op;
        logic                  mem_read;
        logic                  mem_write;
        logic [xlen-1:0]       addr;       // byte address
        logic [3:0]            sel;        // byte lanes touched
        logic [xlen-1:0]       wdata;      // store data already on its lanes
        logic [4:0]            rd;
        logic                  misaligned;
        logic [order_bits-1:0] order;      // stamped by the buffer
    } ctrl_word_t;

    // one record per retired instruction
    typedef struct packed {
        logic [4:0]               rd;
        logic [xlen-1:0]          data;    // extended load data, zero otherwise
        logic                     is_load;
        logic                     fault;   // misaligned, no bus access done
        logic [order_bits-1:0]    order;
        logic [rec_addr_bits-1:0] addr;
    } wb_rec_t;

endpackage
